// ==== Makefile ====
# Verilator build and run of the peak finder testbench

VERILATOR ?= verilator
TOP       ?= sifhTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/frameSequencer.sv ====
/*
 * Frame sequencer
 * Nested sample/pixel/acquisition counters, two-cycle flush,
 * frameDone pulse and pass toggle
 */
`timescale 1ns/1ps
`default_nettype none

`include "sifhCfg.svh"

module frameSequencer (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     wrEn,
    output logic                     accept,
    output sifhFramePkg::pixelIdx_t  pixel,
    output sifhFramePkg::passKind_e  pass,
    output logic                     frameDone
);
    import sifhFramePkg::*;

    sampleIdx_t sampleCnt;
    pixelIdx_t  pixelCnt;
    acqIdx_t    acqCnt;
    logic [1:0] flushSr;
    logic       lastSample;

    // Strobes ignored during flush and frameDone
    assign accept = wrEn && !(|flushSr) && !frameDone;
    assign pixel  = pixelCnt;

    assign lastSample = (sampleCnt == sampleIdx_t'(`SIFH_SAMPLES - 1))
                     && (pixelCnt == pixelIdx_t'(`SIFH_PIXELS - 1))
                     && (acqCnt == acqIdx_t'(`SIFH_ACQS - 1));

    // ********************
    // Position counters
    // ********************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
        end else if (accept) begin
            if (sampleCnt != sampleIdx_t'(`SIFH_SAMPLES - 1)) begin
                sampleCnt <= sampleCnt + 1'b1;
            end else begin
                sampleCnt <= '0;
                // Next pixel, then next acquisition
                if (pixelCnt != pixelIdx_t'(`SIFH_PIXELS - 1)) begin
                    pixelCnt <= pixelCnt + 1'b1;
                end else begin
                    pixelCnt <= '0;
                    if (acqCnt != acqIdx_t'(`SIFH_ACQS - 1)) begin
                        acqCnt <= acqCnt + 1'b1;
                    end else begin
                        acqCnt <= '0;
                    end
                end
            end
        end
    end

    // ********************
    // Flush and pass
    // ********************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            flushSr   <= '0;
            frameDone <= 1'b0;
            pass      <= PASS_COARSE;
        end else begin
            // Two stages after the last sample, then frameDone
            flushSr   <= {flushSr[0], accept && lastSample};
            frameDone <= flushSr[1];
            if (frameDone) begin
                pass <= (pass == PASS_COARSE) ? PASS_FINE : PASS_COARSE;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/histPeakTracker.sv ====
/*
 * Histogram and peak tracker
 * Lazy-cleared saturating bin counts, increment stage, running
 * per-pixel maximum and result capture after the fine pass
 */
`timescale 1ns/1ps
`default_nettype none

`include "sifhCfg.svh"

module histPeakTracker (
    input  logic                                         clk,
    input  logic                                         combin_res,
    input  logic                                         accept,
    input  logic                                         binValid,
    input  sifhSamplePkg::binIdx_t                       bin,
    input  sifhFramePkg::pixelIdx_t                      pixel,
    input  sifhFramePkg::passKind_e                      pass,
    input  logic                                         frameDone,
    input  sifhSamplePkg::stamp_t [`SIFH_PIXELS-1:0]     windowBase,
    output sifhSamplePkg::binIdx_t [`SIFH_PIXELS-1:0]    peakBin,
    output logic [`SIFH_PIXELS*`SIFH_NP-1:0]             result,
    output logic                                         resultValid
);
    import sifhSamplePkg::*;
    import sifhFramePkg::*;

    localparam int DEPTH = `SIFH_PIXELS * `SIFH_BINS;

    binCount_t                         histMem [0:DEPTH-1];
    logic [DEPTH-1:0]                  entryValid;
    logic [`SIFH_PIX_W+`SIFH_NB-1:0]   addr;
    logic                              writeEn;
    binCount_t                         curCount;
    binCount_t                         nextCount;

    // Increment stage
    logic                              incValid;
    binCount_t                         incCount;
    binIdx_t                           incBin;
    pixelIdx_t                         incPixel;

    // Running maximum per pixel
    binCount_t [`SIFH_PIXELS-1:0]      maxCount;
    logic                              fineDone;

    // ********************
    // Histogram store
    // ********************
    // One block of bins per pixel
    assign addr    = {pixel, bin};
    assign writeEn = accept && binValid;

    // Entry without valid bit reads as empty
    assign curCount  = entryValid[addr] ? histMem[addr] : '0;
    // Saturate at full scale
    assign nextCount = (curCount == '1) ? curCount : binCount_t'(curCount + 1'b1);

    always_ff @(posedge clk) begin
        if (writeEn) begin
            histMem[addr] <= nextCount;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            entryValid <= '0;
        end else if (frameDone) begin
            // Lazy clear, counts stay but read as zero
            entryValid <= '0;
        end else if (writeEn) begin
            entryValid[addr] <= 1'b1;
        end
    end

    // ********************
    // Peak tracking
    // ********************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            incValid <= 1'b0;
        end else begin
            incValid <= writeEn;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEn) begin
            incCount <= nextCount;
            incBin   <= bin;
            incPixel <= pixel;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCount <= '0;
            peakBin  <= '0;
        end else if (frameDone) begin
            maxCount <= '0;
            peakBin  <= '0;
        end else if (incValid && (incCount > maxCount[incPixel])) begin
            // Strictly greater, first bin to reach a count keeps it
            maxCount[incPixel] <= incCount;
            peakBin[incPixel]  <= incBin;
        end
    end

    // ********************
    // Result capture
    // ********************
    assign fineDone = frameDone && (pass == PASS_FINE);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= fineDone;
            if (fineDone) begin
                // Fine peak plus window low edge, pixel 0 lowest
                for (int p = 0; p < `SIFH_PIXELS; p++) begin
                    result[p*`SIFH_NP +: `SIFH_NP] <= stamp_t'(peakBin[p]) + windowBase[p];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/sampleFilter.sv ====
/*
 * Sample filter
 * Maps a timestamp to a bin index, coarse by top bits or fine
 * relative to the pixel window, with a drop flag
 */
`timescale 1ns/1ps
`default_nettype none

module sampleFilter (
    input  sifhSamplePkg::stamp_t    data,
    input  sifhFramePkg::passKind_e  pass,
    input  sifhSamplePkg::stamp_t    windowLow,
    input  sifhSamplePkg::stamp_t    windowHigh,
    output logic                     binValid,
    output sifhSamplePkg::binIdx_t   bin
);
    import sifhSamplePkg::*;
    import sifhFramePkg::*;

    sampleWord_u word;
    stamp_t      offset;
    logic        inWindow;

    assign word = sampleWord_u'(data);

    // Fine bin is the distance from the window low edge
    assign inWindow = (word.raw >= windowLow) && (word.raw <= windowHigh);
    assign offset   = word.raw - windowLow;

    always_comb begin
        if (pass == PASS_COARSE) begin
            // Every sample counts in the coarse pass
            bin      = word.split.coarseBin;
            binValid = 1'b1;
        end else begin
            // Outside the window is dropped
            bin      = binIdx_t'(offset);
            binValid = inWindow;
        end
    end

endmodule

`default_nettype wire

// ==== design/sifhCfg.svh ====
/*
 * Widths and frame geometry of the two-pass peak finder
 * Timestamp, bin and counter widths, pixel count, samples and acquisitions
 */
`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// ********************
// Word widths
// ********************
// Timestamp width
`define SIFH_NP 8
// Bin index width, 16 bins per pixel
`define SIFH_NB 4
`define SIFH_BINS (1 << `SIFH_NB)
// Saturating bin counter
`define SIFH_CNT_W 8

// ********************
// Frame geometry
// ********************
`define SIFH_PIXELS 4
`define SIFH_PIX_W ($clog2(`SIFH_PIXELS))
// Consecutive samples per pixel in one acquisition
`define SIFH_SAMPLES 3
// Acquisitions per frame, 48 samples in total
`define SIFH_ACQS 4

`endif

// ==== design/sifhFramePkg.sv ====
/*
 * Types of the frame position and the pass kind
 * Pixel, sample and acquisition indices, coarse/fine pass enum
 */
`default_nettype none

`include "sifhCfg.svh"

package sifhFramePkg;

    // Position inside the frame
    typedef logic [`SIFH_PIX_W-1:0]            pixelIdx_t;
    typedef logic [$clog2(`SIFH_SAMPLES)-1:0] sampleIdx_t;
    typedef logic [$clog2(`SIFH_ACQS)-1:0]    acqIdx_t;

    // Frames alternate, coarse first after reset
    typedef enum logic {
        PASS_COARSE = 1'b0,
        PASS_FINE   = 1'b1
    } passKind_e;

endpackage

`default_nettype wire

// ==== design/sifhSamplePkg.sv ====
/*
 * Types of one timestamp sample
 * Timestamp, bin index, bin count and the two views of a sample word
 */
`default_nettype none

`include "sifhCfg.svh"

package sifhSamplePkg;

    // Full resolution timestamp
    typedef logic [`SIFH_NP-1:0] stamp_t;

    // Histogram bin address within one pixel
    typedef logic [`SIFH_NB-1:0] binIdx_t;

    // Saturating hit count of one bin
    typedef logic [`SIFH_CNT_W-1:0] binCount_t;

    // Coarse view, top bits pick the coarse bin
    typedef struct packed {
        binIdx_t                      coarseBin;
        logic [`SIFH_NP-`SIFH_NB-1:0] fineRest;
    } sampleSplit_s;

    // Same word, raw or split into coarse/fine fields
    typedef union packed {
        stamp_t       raw;
        sampleSplit_s split;
    } sampleWord_u;

endpackage

`default_nettype wire

// ==== design/sifhTop.sv ====
/*
 * Two-pass peak finder top level
 * Sequencer, sample filter, window registers and histogram tracker
 */
`timescale 1ns/1ps
`default_nettype none

`include "sifhCfg.svh"

module sifhTop (
    input  logic                              clk,
    input  logic                              combin_res,
    input  logic                              wrEn,
    input  sifhSamplePkg::stamp_t             data,
    output logic [`SIFH_PIXELS*`SIFH_NP-1:0]  result,
    output logic                              resultValid,
    output logic                              coarsePass
);
    import sifhSamplePkg::*;
    import sifhFramePkg::*;

    // Sequencer outputs
    logic                          accept;
    pixelIdx_t                     pixel;
    passKind_e                     pass;
    logic                          frameDone;

    // Filter outputs
    logic                          binValid;
    binIdx_t                       bin;

    // Window and peak state
    stamp_t                        windowLow;
    stamp_t                        windowHigh;
    stamp_t [`SIFH_PIXELS-1:0]     windowBase;
    binIdx_t [`SIFH_PIXELS-1:0]    peakBin;

    assign coarsePass = (pass == PASS_COARSE);

    frameSequencer u_frameSequencer (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .accept     (accept),
        .pixel      (pixel),
        .pass       (pass),
        .frameDone  (frameDone)
    );

    sampleFilter u_sampleFilter (
        .data       (data),
        .pass       (pass),
        .windowLow  (windowLow),
        .windowHigh (windowHigh),
        .binValid   (binValid),
        .bin        (bin)
    );

    windowRegs u_windowRegs (
        .clk        (clk),
        .combin_res (combin_res),
        .frameDone  (frameDone),
        .pass       (pass),
        .peakBin    (peakBin),
        .pixel      (pixel),
        .windowLow  (windowLow),
        .windowHigh (windowHigh),
        .windowBase (windowBase)
    );

    histPeakTracker u_histPeakTracker (
        .clk         (clk),
        .combin_res  (combin_res),
        .accept      (accept),
        .binValid    (binValid),
        .bin         (bin),
        .pixel       (pixel),
        .pass        (pass),
        .frameDone   (frameDone),
        .windowBase  (windowBase),
        .peakBin     (peakBin),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

// ==== design/windowRegs.sv ====
/*
 * Per-pixel window registers
 * Clamped window low edge from the coarse peak, loaded at frame end,
 * and the window of the current pixel for the sample filter
 */
`timescale 1ns/1ps
`default_nettype none

`include "sifhCfg.svh"

module windowRegs (
    input  logic                                        clk,
    input  logic                                        combin_res,
    input  logic                                        frameDone,
    input  sifhFramePkg::passKind_e                     pass,
    input  sifhSamplePkg::binIdx_t [`SIFH_PIXELS-1:0]   peakBin,
    input  sifhFramePkg::pixelIdx_t                     pixel,
    output sifhSamplePkg::stamp_t                       windowLow,
    output sifhSamplePkg::stamp_t                       windowHigh,
    output sifhSamplePkg::stamp_t [`SIFH_PIXELS-1:0]    windowBase
);
    import sifhSamplePkg::*;
    import sifhFramePkg::*;

    // Half the window width
    localparam stamp_t HALF_WIDTH = stamp_t'(2 ** (`SIFH_NB - 1));
    // Highest low edge that keeps the window in range
    localparam stamp_t LOW_LIMIT  = stamp_t'(2 ** `SIFH_NP - 2 ** `SIFH_NB);
    // High edge offset, width minus one
    localparam stamp_t SPAN       = stamp_t'(2 ** `SIFH_NB - 1);

    // Low edge of the window centred on a coarse bin
    function automatic stamp_t clampLow(input binIdx_t peak);
        stamp_t centre;
        centre = {peak, {(`SIFH_NP - `SIFH_NB){1'b0}}};
        // Clamp at the bottom
        if (centre < HALF_WIDTH) begin
            return '0;
        end
        // Clamp at the top
        if (centre - HALF_WIDTH > LOW_LIMIT) begin
            return LOW_LIMIT;
        end
        return centre - HALF_WIDTH;
    endfunction

    // ********************
    // Window store
    // ********************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windowBase <= '0;
        end else if (frameDone && (pass == PASS_COARSE)) begin
            // Coarse peaks ready, set up the fine pass
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                windowBase[p] <= clampLow(peakBin[p]);
            end
        end
    end

    // Window of the pixel now receiving samples
    assign windowLow  = windowBase[pixel];
    assign windowHigh = windowLow + SPAN;

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
+incdir+test
design/sifhSamplePkg.sv
design/sifhFramePkg.sv
design/frameSequencer.sv
design/sampleFilter.sv
design/windowRegs.sv
design/histPeakTracker.sv
design/sifhTop.sv
test/sifhTb.sv

// ==== test/sifhTbModel.svh ====
/*
 * Testbench helpers for the peak finder
 * Galois LFSR random source, window rule and histogram peak model
 */
`ifndef SIFH_TB_MODEL_SVH
`define SIFH_TB_MODEL_SVH

// One Galois step, taps of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
endfunction

// One LFSR step per bit of the timestamp
function automatic stamp_t randomStamp();
    stamp_t val;
    val = '0;
    for (int i = 0; i < `SIFH_NP; i++) begin
        val       = {val[`SIFH_NP-2:0], lfsrState[0]};
        lfsrState = lfsrNext(lfsrState);
    end
    return val;
endfunction

// Window low edge around a coarse peak, clamped to the timestamp range
function automatic int modelLow(input int coarsePeak);
    int low;
    low = (coarsePeak << (`SIFH_NP - `SIFH_NB)) - (`SIFH_BINS / 2);
    if (low < 0) begin
        low = 0;
    end
    if (low > (1 << `SIFH_NP) - `SIFH_BINS) begin
        low = (1 << `SIFH_NP) - `SIFH_BINS;
    end
    return low;
endfunction

// Peak bin of one pixel over frameData in arrival order
function automatic int modelPeak(input int pix, input bit fine, input int low);
    int counts [`SIFH_BINS];
    int maxCnt;
    int peak;
    int stamp;
    int b;
    maxCnt = 0;
    peak   = 0;
    foreach (counts[j]) begin
        counts[j] = 0;
    end
    for (int i = 0; i < FRAME_SAMPLES; i++) begin
        // Samples of a pixel come in runs of SAMPLES
        if ((i / `SIFH_SAMPLES) % `SIFH_PIXELS == pix) begin
            stamp = int'(frameData[i]);
            b     = -1;
            if (!fine) begin
                b = stamp >> (`SIFH_NP - `SIFH_NB);
            end else if (stamp >= low && stamp < low + `SIFH_BINS) begin
                b = stamp - low;
            end
            // At most 12 hits, far below saturation
            if (b >= 0) begin
                counts[b]++;
                if (counts[b] > maxCnt) begin
                    maxCnt = counts[b];
                    peak   = b;
                end
            end
        end
    end
    return peak;
endfunction

`endif

// ==== test/sifhTb.sv ====
/*
 * Testbench of the two-pass peak finder
 * Clock and reset, coarse/fine frame stimulus, model based expected
 * results, concurrent assertions, per-test and closing report
 */
`timescale 1ns/1ps
`default_nettype none

`include "sifhCfg.svh"

module sifhTb;
    import sifhSamplePkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int FRAME_SAMPLES = `SIFH_SAMPLES * `SIFH_PIXELS * `SIFH_ACQS;
    localparam int IDLE_CYCLES   = 4;
    // Frame pair plus settle, five pairs in all, four times margin
    localparam int PAIR_LEN      = 2 * (FRAME_SAMPLES + IDLE_CYCLES) + 2;
    localparam int MAX_CYCLES    = 4 * (RESET_CYCLES + 5 * PAIR_LEN + 4);

    logic                             clk;
    logic                             combin_res;
    logic                             wrEn;
    stamp_t                           data;
    logic [`SIFH_PIXELS*`SIFH_NP-1:0] result;
    logic                             resultValid;
    logic                             coarsePass;

    // Expected values seen by the assertions
    logic                             checkReset;
    logic                             pulseDue;
    logic                             expCoarse;
    logic [`SIFH_PIXELS*`SIFH_NP-1:0] expResult;

    logic [31:0] lfsrState;
    stamp_t      frameData [FRAME_SAMPLES];
    stamp_t      targets [`SIFH_PIXELS];
    int          errCount;
    int          testsRun;
    int          testsFailed;
    int          resultPulses;
    int          pairsRun;
    int          cycleCnt;

    `include "sifhTbModel.svh"

    sifhTop u_sifhTop (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .result      (result),
        .resultValid (resultValid),
        .coarsePass  (coarsePass)
    );

    always #20 clk = ~clk;

    // ********************
    // Checks
    // ********************
    task automatic reportMismatch(input string sigName, input logic [63:0] got,
                                  input logic [63:0] exp);
        $display("FAILED at %0t: %s is %h, expected %h", $time, sigName, got, exp);
        errCount++;
    endtask

    resetValidCheck: assert property (@(posedge clk) checkReset |-> !resultValid)
        else reportMismatch("resultValid", 64'($sampled(resultValid)), 64'd0);
    resetPassCheck: assert property (@(posedge clk) checkReset |-> coarsePass)
        else reportMismatch("coarsePass", 64'($sampled(coarsePass)), 64'd1);
    resetResultCheck: assert property (@(posedge clk) checkReset |-> (result == '0))
        else reportMismatch("result", 64'($sampled(result)), 64'd0);

    // Pulse only when due, three cycles after the last fine sample
    pulseCheck: assert property (@(posedge clk) disable iff (!combin_res)
                                 resultValid == pulseDue)
        else reportMismatch("resultValid", 64'($sampled(resultValid)),
                            64'($sampled(pulseDue)));
    resultCheck: assert property (@(posedge clk) disable iff (!combin_res)
                                  resultValid |-> (result == expResult))
        else reportMismatch("result", 64'($sampled(result)), 64'($sampled(expResult)));
    passCheck: assert property (@(posedge clk) disable iff (!combin_res)
                                coarsePass == expCoarse)
        else reportMismatch("coarsePass", 64'($sampled(coarsePass)),
                            64'($sampled(expCoarse)));

    // Mid-cycle count of result pulses
    always @(negedge clk) begin
        if (combin_res && resultValid) begin
            resultPulses++;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycleCnt++;
        if (cycleCnt >= MAX_CYCLES) begin
            $display("Run aborted, still running after %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // ********************
    // Stimulus
    // ********************
    task automatic chooseTargets();
        for (int p = 0; p < `SIFH_PIXELS; p++) begin
            targets[p] = randomStamp();
        end
    endtask

    // Sparse frames carry one target per run, the rest random
    task automatic buildFrame(input bit sparse);
        int idx;
        for (int a = 0; a < `SIFH_ACQS; a++) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                for (int s = 0; s < `SIFH_SAMPLES; s++) begin
                    idx = (a * `SIFH_PIXELS + p) * `SIFH_SAMPLES + s;
                    if (sparse ? (s == 0) : (s < 2)) begin
                        frameData[idx] = targets[p];
                    end else begin
                        frameData[idx] = randomStamp();
                    end
                end
            end
        end
    endtask

    // Back to back samples, then the idle gap
    task automatic sendFrame(input bit fine);
        for (int i = 0; i < FRAME_SAMPLES; i++) begin
            @(posedge clk);
            wrEn     <= 1'b1;
            data     <= frameData[i];
            pulseDue <= 1'b0;
        end
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(posedge clk);
            wrEn     <= 1'b0;
            data     <= '0;
            pulseDue <= fine && (i == IDLE_CYCLES - 1);
            // Pass flips on the last idle edge
            if (i == IDLE_CYCLES - 1) begin
                expCoarse <= !expCoarse;
            end
        end
    endtask

    task automatic runPair(input bit sparseFine);
        int                               winLow [`SIFH_PIXELS];
        logic [`SIFH_PIXELS*`SIFH_NP-1:0] nextExp;
        buildFrame(1'b0);
        for (int p = 0; p < `SIFH_PIXELS; p++) begin
            winLow[p] = modelLow(modelPeak(p, 1'b0, 0));
        end
        sendFrame(1'b0);
        buildFrame(sparseFine);
        for (int p = 0; p < `SIFH_PIXELS; p++) begin
            nextExp[p*`SIFH_NP +: `SIFH_NP] = stamp_t'(winLow[p] + modelPeak(p, 1'b1, winLow[p]));
        end
        expResult <= nextExp;
        sendFrame(1'b1);
        pairsRun++;
    endtask

    // Lets the pulse check of the last frame complete
    task automatic settle();
        @(posedge clk);
        wrEn     <= 1'b0;
        pulseDue <= 1'b0;
        @(posedge clk);
    endtask

    task automatic endTest(input string name, input int errMark);
        testsRun++;
        if (errCount == errMark) begin
            $display("test %0d %s: passed", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d errors", testsRun, name,
                     errCount - errMark);
        end
    endtask

    // ********************
    // Test sequence
    // ********************
    initial begin
        int errMark;
        clk          = 1'b0;
        combin_res   = 1'b0;
        wrEn         = 1'b0;
        data         = '0;
        checkReset   = 1'b0;
        pulseDue     = 1'b0;
        expCoarse    = 1'b1;
        expResult    = '0;
        lfsrState    = 32'h2ea3_240c;
        errCount     = 0;
        testsRun     = 0;
        testsFailed  = 0;
        resultPulses = 0;
        pairsRun     = 0;
        cycleCnt     = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        combin_res <= 1'b1;

        errMark = errCount;
        @(posedge clk);
        checkReset <= 1'b1;
        @(posedge clk);
        checkReset <= 1'b0;
        @(posedge clk);
        endTest("outputs after reset", errMark);

        errMark = errCount;
        chooseTargets();
        runPair(1'b0);
        settle();
        endTest("random targets pair", errMark);

        // Fine frame mostly outside the windows
        errMark = errCount;
        chooseTargets();
        runPair(1'b1);
        settle();
        endTest("dropped fine samples", errMark);

        errMark = errCount;
        targets[0] = 8'd2;
        targets[1] = 8'd253;
        targets[2] = 8'd9;
        targets[3] = 8'd246;
        runPair(1'b0);
        settle();
        endTest("targets at range edges", errMark);

        // Two pairs, nothing may carry over
        errMark = errCount;
        chooseTargets();
        runPair(1'b0);
        settle();
        chooseTargets();
        runPair(1'b0);
        settle();
        endTest("repeated pairs", errMark);

        if (resultPulses != pairsRun) begin
            reportMismatch("resultPulses", 64'(resultPulses), 64'(pairsRun));
        end
        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed,
                 errCount);
        if (errCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
